/* Bender.yml */
package:
  name: bbox_iterator

sources:
  - include_dirs:
      - logic
    files:
      - logic/raster_geom_pkg.sv
      - logic/raster_prim_pkg.sv
      - logic/column_stepper.sv
      - logic/row_stepper.sv
      - logic/walk_control.sv
      - logic/bbox_iterator.sv

  - target: test
    include_dirs:
      - logic
    files:
      - verification/bbox_iterator_asserts.sv
      - verification/bbox_iterator_tb.sv

/* bbox_iterator.f */
+incdir+logic
logic/raster_geom_pkg.sv
logic/raster_prim_pkg.sv
logic/column_stepper.sv
logic/row_stepper.sv
logic/walk_control.sv
logic/bbox_iterator.sv
verification/bbox_iterator_asserts.sv
verification/bbox_iterator_tb.sv

/* logic/bbox_iterator.sv */
`default_nettype none

`include "raster_consts.svh"

module bbox_iterator
    import raster_geom_pkg::*;
    import raster_prim_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  prim_attr_t    attr_in,
    input  bbox_t         box_in,
    input  logic          tri_valid,
    input  msaa_mode_t    msaa_mode,
    output sample_lanes_t samples,
    output lane_mask_t    sample_valid,
    output prim_attr_t    attr_out,
    output logic          halt
);

    // Command shared by both steppers
    walk_cmd_t cmd;

    // Edge flags back to the controller
    logic right_edge;
    logic top_edge;

    // Shared x and per lane y
    coord_t                     x;
    coord_t [`RASTER_LANES-1:0] lane_y;

    column_stepper u_column (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .box_in     (box_in),
        .msaa_mode  (msaa_mode),
        .x          (x),
        .right_edge (right_edge)
    );

    row_stepper u_row (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .box_in    (box_in),
        .msaa_mode (msaa_mode),
        .lane_y    (lane_y),
        .top_edge  (top_edge)
    );

    walk_control u_control (
        .clk          (clk),
        .rst          (rst),
        .tri_valid    (tri_valid),
        .attr_in      (attr_in),
        .right_edge   (right_edge),
        .top_edge     (top_edge),
        .cmd          (cmd),
        .attr_out     (attr_out),
        .sample_valid (sample_valid),
        .halt         (halt)
    );

    // Every lane in the stack sits in the same column
    always_comb begin
        for (int i = 0; i < `RASTER_LANES; i++) begin
            samples[i].x = x;
            samples[i].y = lane_y[i];
        end
    end

endmodule

`default_nettype wire

/* logic/column_stepper.sv */
`default_nettype none

module column_stepper
    import raster_geom_pkg::*;
    import raster_prim_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  walk_cmd_t  cmd,
    input  bbox_t      box_in,
    input  msaa_mode_t msaa_mode,
    output coord_t     x,
    output logic       right_edge
);

    // Latched horizontal bounds of the current box
    coord_t left_x;
    coord_t right_x;

    // Horizontal distance between neighbouring samples
    coord_t pitch;

    // Mode is decoded live, it only changes between triangles
    assign pitch = sample_pitch(msaa_mode);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x       <= '0;
            left_x  <= '0;
            right_x <= '0;
        end else begin
            case (cmd)
                CMD_LOAD: begin
                    // Start at the left edge and capture both bounds
                    x       <= box_in.ll.x;
                    left_x  <= box_in.ll.x;
                    right_x <= box_in.ur.x;
                end
                CMD_RIGHT: begin
                    x <= x + pitch;
                end
                CMD_UP: begin
                    // New lane group starts back at the left edge
                    x <= left_x;
                end
                default: begin
                    x <= x;
                end
            endcase
        end
    end

    // At or past the right bound, signed compare
    assign right_edge = (x >= right_x);

endmodule

`default_nettype wire

/* logic/raster_consts.svh */
`ifndef RASTER_CONSTS_SVH
`define RASTER_CONSTS_SVH

// Bits in a signed fixed-point coordinate or color channel
`define RASTER_SIGFIG 24

// Fraction bits, the integer part sits above them
`define RASTER_RADIX 10

// Vertices per triangle
`define RASTER_VERTS 3

// Axes per vertex, x y z
`define RASTER_AXIS 3

// Color channels per triangle
`define RASTER_COLORS 3

// Vertically stacked samples produced each cycle
`define RASTER_LANES 4

`endif

/* logic/raster_geom_pkg.sv */
`default_nettype none

package raster_geom_pkg;

    `include "raster_consts.svh"

    // Signed fixed point, RASTER_RADIX fraction bits
    typedef logic signed [`RASTER_SIGFIG-1:0] coord_t;

    // Screen position of one sample
    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    // Integer aligned box, lower left and upper right corners
    typedef struct packed {
        point_t ll;
        point_t ur;
    } bbox_t;

    // Lane 0 is the lowest sample of the stack
    typedef point_t [`RASTER_LANES-1:0] sample_lanes_t;

    // One valid bit per lane
    typedef logic [`RASTER_LANES-1:0] lane_mask_t;

    // Step command for the next rising edge
    typedef enum logic [1:0] {
        CMD_LOAD,
        CMD_RIGHT,
        CMD_UP
    } walk_cmd_t;

    // One-hot mode to pitch, bit 3 is one pixel and bit 0 an eighth
    function automatic coord_t sample_pitch(input logic [3:0] mode);
        return coord_t'({mode, {(`RASTER_RADIX - 3){1'b0}}});
    endfunction

endpackage

`default_nettype wire

/* logic/raster_prim_pkg.sv */
`default_nettype none

package raster_prim_pkg;

    `include "raster_consts.svh"

    import raster_geom_pkg::*;

    // One vertex, x y z in fixed point
    typedef coord_t [`RASTER_AXIS-1:0] vertex_t;

    // Whole triangle travelling with its samples
    typedef vertex_t [`RASTER_VERTS-1:0] triangle_t;

    // Unsigned color channel, same width as a coordinate
    typedef logic [`RASTER_SIGFIG-1:0] channel_t;

    typedef channel_t [`RASTER_COLORS-1:0] color_t;

    // Everything the sample test needs besides the positions
    typedef struct packed {
        triangle_t triangle;
        color_t    color;
    } prim_attr_t;

    // One-hot multisample mode
    // 1000 is 1x, 0100 is 4x, 0010 is 16x, 0001 is 64x
    typedef logic [3:0] msaa_mode_t;

endpackage

`default_nettype wire

/* logic/row_stepper.sv */
`default_nettype none

`include "raster_consts.svh"

module row_stepper
    import raster_geom_pkg::*;
    import raster_prim_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  walk_cmd_t                    cmd,
    input  bbox_t                        box_in,
    input  msaa_mode_t                   msaa_mode,
    output coord_t [`RASTER_LANES-1:0]   lane_y,
    output logic                         top_edge
);

    // Latched top bound of the current box
    coord_t top_y;

    // Vertical pitch between lanes and between lane groups
    coord_t pitch;
    coord_t group_step;

    // Per lane top comparison
    lane_mask_t lane_at_top;

    assign pitch = sample_pitch(msaa_mode);

    // A group is RASTER_LANES samples tall
    assign group_step = coord_t'(`RASTER_LANES * pitch);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            top_y  <= '0;
            lane_y <= '0;
        end else begin
            case (cmd)
                CMD_LOAD: begin
                    top_y <= box_in.ur.y;
                    // Stack the lanes upward from the bottom bound
                    for (int i = 0; i < `RASTER_LANES; i++) begin
                        lane_y[i] <= box_in.ll.y + coord_t'(i) * pitch;
                    end
                end
                CMD_UP: begin
                    // Whole stack moves one group up
                    for (int i = 0; i < `RASTER_LANES; i++) begin
                        lane_y[i] <= lane_y[i] + group_step;
                    end
                end
                default: begin
                    // CMD_RIGHT keeps the rows where they are
                    lane_y <= lane_y;
                end
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < `RASTER_LANES; i++) begin
            lane_at_top[i] = (lane_y[i] >= top_y);
        end
    end

    // Top reached only once every lane is at or past the bound
    assign top_edge = &lane_at_top;

endmodule

`default_nettype wire

/* logic/walk_control.sv */
`default_nettype none

module walk_control
    import raster_geom_pkg::*;
    import raster_prim_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       tri_valid,
    input  prim_attr_t attr_in,
    input  logic       right_edge,
    input  logic       top_edge,
    output walk_cmd_t  cmd,
    output prim_attr_t attr_out,
    output lane_mask_t sample_valid,
    output logic       halt
);

    // Waiting for a triangle, or walking its box
    typedef enum logic {
        ST_WAIT,
        ST_WALK
    } walk_state_t;

    walk_state_t state;
    walk_state_t next_state;

    // Next command and next state from the current edge flags
    always_comb begin
        cmd        = CMD_LOAD;
        next_state = state;
        case (state)
            ST_WAIT: begin
                // Keep loading the input box until a triangle shows up
                cmd = CMD_LOAD;
                if (tri_valid) begin
                    next_state = ST_WALK;
                end
            end
            ST_WALK: begin
                if (right_edge && top_edge) begin
                    // Last group done, park on the input box again
                    cmd        = CMD_LOAD;
                    next_state = ST_WAIT;
                end else if (right_edge) begin
                    // End of a row of groups, go up one group
                    cmd = CMD_UP;
                end else begin
                    cmd = CMD_RIGHT;
                end
            end
            default: begin
                cmd        = CMD_LOAD;
                next_state = ST_WAIT;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= ST_WAIT;
            sample_valid <= '0;
        end else begin
            state <= next_state;
            // All lanes share one valid, set for every walking cycle
            sample_valid <= (next_state == ST_WALK) ? '1 : '0;
        end
    end

    // Attributes follow the input on every load and freeze during the walk
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            attr_out <= '0;
        end else if (cmd == CMD_LOAD) begin
            attr_out <= attr_in;
        end
    end

    // Upstream holds its triangle for as long as we walk
    assign halt = (state == ST_WALK);

endmodule

`default_nettype wire

/* verification/bbox_iterator_asserts.sv */
`default_nettype none

`include "raster_consts.svh"

module bbox_iterator_asserts
    import raster_geom_pkg::*;
(
    input wire logic          clk,
    input wire logic          rst,
    input wire logic          tri_valid,
    input wire logic          halt,
    input wire lane_mask_t    sample_valid,
    input wire sample_lanes_t samples,
    input wire logic          right_edge,
    input wire logic          top_edge
);

    // Failed properties so far, read back at the end of the run
    int unsigned fail_count = 0;

    // All lanes of the stack in one column
    logic same_x;

    always_comb begin
        same_x = 1'b1;
        for (int i = 1; i < `RASTER_LANES; i++) begin
            if (samples[i].x != samples[0].x) begin
                same_x = 1'b0;
            end
        end
    end

    // Consuming edge starts the walk with every lane valid
    consume_starts_walk: assert property (@(posedge clk) disable iff (rst)
        (!halt && tri_valid) |=> (halt && sample_valid == '1)
    ) else begin
        $error("consumed triangle did not start a walk");
        fail_count++;
    end

    // Lane valids move as one and track halt
    lanes_follow_halt: assert property (@(posedge clk) disable iff (rst)
        halt ? (sample_valid == '1) : (sample_valid == '0)
    ) else begin
        $error("lane valids disagree with halt");
        fail_count++;
    end

    walk_shares_x: assert property (@(posedge clk) disable iff (rst)
        halt |-> same_x
    ) else begin
        $error("lanes in one cycle have different x");
        fail_count++;
    end

    // Both edges reached ends the walk
    corner_ends_walk: assert property (@(posedge clk) disable iff (rst)
        (halt && right_edge && top_edge) |=> !halt
    ) else begin
        $error("walk did not end at the top right corner");
        fail_count++;
    end

endmodule

bind bbox_iterator bbox_iterator_asserts u_asserts (
    .clk          (clk),
    .rst          (rst),
    .tri_valid    (tri_valid),
    .halt         (halt),
    .sample_valid (sample_valid),
    .samples      (samples),
    .right_edge   (right_edge),
    .top_edge     (top_edge)
);

`default_nettype wire

/* verification/bbox_iterator_tb.sv */
`default_nettype none

`include "raster_consts.svh"

module bbox_iterator_tb
    import raster_geom_pkg::*;
    import raster_prim_pkg::*;
();

    localparam int DRIVE_DELAY    = 10;
    localparam int TIMEOUT_CYCLES = 2000;

    logic          clk;
    logic          rst;
    prim_attr_t    attr_in;
    bbox_t         box_in;
    logic          tri_valid;
    msaa_mode_t    msaa_mode;
    sample_lanes_t samples;
    lane_mask_t    sample_valid;
    prim_attr_t    attr_out;
    logic          halt;

    integer seed;
    int     errors;
    int     tests_run;
    int     tests_failed;
    int     samples_seen;
    string  cur_test;

    // Expected sample stacks in walk order, with the attributes of their triangle
    sample_lanes_t exp_q[$];
    prim_attr_t    exp_attr_q[$];

    bbox_iterator dut0 (
        .clk          (clk),
        .rst          (rst),
        .attr_in      (attr_in),
        .box_in       (box_in),
        .tri_valid    (tri_valid),
        .msaa_mode    (msaa_mode),
        .samples      (samples),
        .sample_valid (sample_valid),
        .attr_out     (attr_out),
        .halt         (halt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Pitch from the mode's meaning, one pixel down to an eighth
    function automatic coord_t ref_pitch(input msaa_mode_t mode);
        coord_t one_px;
        one_px = coord_t'(1 << `RASTER_RADIX);
        case (mode)
            4'b1000: return one_px;
            4'b0100: return one_px >>> 1;
            4'b0010: return one_px >>> 2;
            default: return one_px >>> 3;
        endcase
    endfunction

    // One plus the span in steps rounded up, one for an empty span
    function automatic int step_count(input coord_t span, input coord_t step);
        if (span <= 0) begin
            return 1;
        end
        return 1 + (span + step - 1) / step;
    endfunction

    // Reference walk, groups bottom to top and columns left to right
    function automatic int build_expected(input bbox_t box, input msaa_mode_t mode,
                                          input prim_attr_t attr);
        coord_t        p;
        int            cols;
        int            groups;
        sample_lanes_t s;
        p      = ref_pitch(mode);
        cols   = step_count(box.ur.x - box.ll.x, p);
        groups = step_count(box.ur.y - box.ll.y, coord_t'(`RASTER_LANES) * p);
        for (int g = 0; g < groups; g++) begin
            for (int c = 0; c < cols; c++) begin
                for (int i = 0; i < `RASTER_LANES; i++) begin
                    s[i].x = box.ll.x + coord_t'(c) * p;
                    s[i].y = box.ll.y + coord_t'(g * `RASTER_LANES + i) * p;
                end
                exp_q.push_back(s);
                exp_attr_q.push_back(attr);
            end
        end
        return cols * groups;
    endfunction

    // Small integer aligned box in the positive quadrant
    function automatic bbox_t random_box(input int max_px);
        bbox_t b;
        int    w;
        int    h;
        b.ll.x = coord_t'(($unsigned($random(seed)) % 16) << `RASTER_RADIX);
        b.ll.y = coord_t'(($unsigned($random(seed)) % 16) << `RASTER_RADIX);
        w      = $unsigned($random(seed)) % (max_px + 1);
        h      = $unsigned($random(seed)) % (max_px + 1);
        b.ur.x = b.ll.x + coord_t'(w << `RASTER_RADIX);
        b.ur.y = b.ll.y + coord_t'(h << `RASTER_RADIX);
        return b;
    endfunction

    function automatic prim_attr_t random_attr();
        prim_attr_t a;
        for (int v = 0; v < `RASTER_VERTS; v++) begin
            for (int k = 0; k < `RASTER_AXIS; k++) begin
                a.triangle[v][k] = coord_t'($random(seed));
            end
        end
        for (int c = 0; c < `RASTER_COLORS; c++) begin
            a.color[c] = channel_t'($random(seed));
        end
        return a;
    endfunction

    task automatic compare_samples(input string name, input sample_lanes_t exp,
                                   input sample_lanes_t act);
        if (exp !== act) begin
            $display("Mismatch %s samples: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_attr(input string name, input prim_attr_t exp,
                                input prim_attr_t act);
        if (exp !== act) begin
            $display("Mismatch %s attr_out: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_mask(input string name, input lane_mask_t exp,
                                input lane_mask_t act);
        if (exp !== act) begin
            $display("Mismatch %s sample_valid: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    // Outputs settle after the rising edge, sampled mid cycle
    always @(negedge clk) begin
        if (!rst && sample_valid !== '0) begin
            samples_seen++;
            if (exp_q.size() == 0) begin
                $display("%s: valid samples appeared with none expected", cur_test);
                errors++;
            end else begin
                compare_samples(cur_test, exp_q.pop_front(), samples);
                compare_attr(cur_test, exp_attr_q.pop_front(), attr_out);
                compare_mask(cur_test, '1, sample_valid);
            end
        end
    end

    task automatic next_drive_point();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic wait_halt(input logic level, output bit ok);
        ok = 1'b0;
        for (int n = 0; n < TIMEOUT_CYCLES; n++) begin
            if (halt === level) begin
                ok = 1'b1;
                return;
            end
            next_drive_point();
        end
        $display("%s: timed out waiting for halt to become %b", cur_test, level);
        errors++;
    endtask

    task automatic present(input bbox_t box, input msaa_mode_t mode, input prim_attr_t attr);
        box_in    = box;
        msaa_mode = mode;
        attr_in   = attr;
        tri_valid = 1'b1;
    endtask

    task automatic begin_test(input string name, output int start_errors);
        cur_test     = name;
        start_errors = errors;
        samples_seen = 0;
    endtask

    task automatic finish_test(input int start_errors);
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected sample cycles never appeared", cur_test, exp_q.size());
            errors++;
        end
        exp_q.delete();
        exp_attr_q.delete();
        tests_run++;
        if (errors != start_errors) begin
            tests_failed++;
            $display("test %s: FAIL, %0d errors", cur_test, errors - start_errors);
        end else begin
            $display("test %s: ok, %0d sample cycles", cur_test, samples_seen);
        end
    endtask

    // One triangle, upstream drops tri_valid once it is taken
    task automatic run_single(input string name, input bbox_t box, input msaa_mode_t mode);
        int         start_errors;
        bit         ok;
        prim_attr_t attr;
        begin_test(name, start_errors);
        attr = random_attr();
        void'(build_expected(box, mode, attr));
        wait_halt(1'b0, ok);
        if (ok) begin
            present(box, mode, attr);
            next_drive_point();
            tri_valid = 1'b0;
            wait_halt(1'b0, ok);
        end
        finish_test(start_errors);
    endtask

    task automatic run_back_to_back();
        int         start_errors;
        bit         ok;
        bbox_t      b1;
        bbox_t      b2;
        prim_attr_t a1;
        prim_attr_t a2;
        begin_test("back_to_back", start_errors);
        b1 = random_box(2);
        b2 = random_box(2);
        a1 = random_attr();
        a2 = random_attr();
        void'(build_expected(b1, 4'b0100, a1));
        void'(build_expected(b2, 4'b0100, a2));
        wait_halt(1'b0, ok);
        if (ok) begin
            present(b1, 4'b0100, a1);
            next_drive_point();
            // Second triangle waits behind the first, same mode
            present(b2, 4'b0100, a2);
            wait_halt(1'b0, ok);
        end
        if (ok) begin
            compare_mask(cur_test, '0, sample_valid);
            next_drive_point();
            tri_valid = 1'b0;
            if (halt !== 1'b1) begin
                $display("%s: second triangle not taken after one idle cycle", cur_test);
                errors++;
            end
            wait_halt(1'b0, ok);
        end
        if (ok) begin
            // A repeated walk would show up as extra samples
            repeat (4) next_drive_point();
            if (halt !== 1'b0) begin
                $display("%s: second triangle was taken more than once", cur_test);
                errors++;
            end
        end
        finish_test(start_errors);
    endtask

    initial begin
        int start_errors;
        seed         = 88;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        samples_seen = 0;
        cur_test     = "reset";
        rst          = 1'b1;
        tri_valid    = 1'b0;
        attr_in      = '0;
        box_in       = '0;
        msaa_mode    = 4'b1000;
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        begin_test("reset_idle", start_errors);
        repeat (3) begin
            next_drive_point();
            compare_mask(cur_test, '0, sample_valid);
            if (halt !== 1'b0) begin
                $display("Mismatch %s halt: expected 0, actual %b", cur_test, halt);
                errors++;
            end
        end
        finish_test(start_errors);

        run_single("single_point_1x", '{ll: '{x: 24'h000c00, y: 24'h001400},
                                       ur: '{x: 24'h000c00, y: 24'h001400}}, 4'b1000);
        run_single("multi_group_4x", '{ll: '{x: 24'h000800, y: 24'h000400},
                                      ur: '{x: 24'h001000, y: 24'h001000}}, 4'b0100);
        for (int k = 0; k < 3; k++) begin
            run_single($sformatf("random_1x_%0d", k), random_box(3), 4'b1000);
            run_single($sformatf("random_16x_%0d", k), random_box(3), 4'b0010);
            run_single($sformatf("random_64x_%0d", k), random_box(3), 4'b0001);
        end
        run_back_to_back();

        if (dut0.u_asserts.fail_count != 0) begin
            $display("%0d assertion failures during the run", dut0.u_asserts.fail_count);
            errors += dut0.u_asserts.fail_count;
        end
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
